/* include/noc_route_params.svh */
`ifndef NOC_ROUTE_PARAMS_SVH
`define NOC_ROUTE_PARAMS_SVH

// serial link, one flit per cycle
`define NR_FLIT_W 4

// full source-route header
`define NR_HDR_W 16

// output port number, consumed from the header low bits at each hop
`define NR_PORT_W 3

// apb byte address and data bus
`define NR_APB_AW 4
`define NR_APB_DW 32

// event counters
`define NR_CNT_W 16

`endif

/* hw/noc_route_pkg.sv */
`default_nettype none

`include "noc_route_params.svh"

package noc_route_pkg;

    localparam int FLIT_W = `NR_FLIT_W;
    localparam int HDR_W = `NR_HDR_W;
    localparam int PORT_W = `NR_PORT_W;
    localparam int NUM_PORTS = 1 << PORT_W;
    localparam int FLITS_PER_HDR = HDR_W / FLIT_W;
    localparam int APB_AW = `NR_APB_AW;
    localparam int APB_DW = `NR_APB_DW;
    localparam int CNT_W = `NR_CNT_W;

    typedef logic [FLIT_W-1:0] flit_t;
    typedef logic [HDR_W-1:0] route_hdr_t;
    typedef logic [PORT_W-1:0] port_id_t;
    typedef logic [NUM_PORTS-1:0] port_mask_t;
    typedef logic [CNT_W-1:0] count_t;

    // steering from the register block
    typedef struct packed {
        port_mask_t port_enable;
        port_id_t fallback_port;
    } route_cfg_t;

    // one-cycle pulses back to the counters
    typedef struct packed {
        logic routed;
        logic redirected;
    } route_event_t;

    // datapath strobes, at most one per cycle
    typedef struct packed {
        logic shift_in;
        logic load_route;
        logic shift_out;
    } seq_ctrl_t;

    typedef enum logic [2:0] {
        IDLE,
        COLLECT,
        ROUTE,
        SEND,
        HOLD
    } seq_state_t;

endpackage

`default_nettype wire

/* hw/route_compute.sv */
`timescale 1ns/1ns
`default_nettype none

module route_compute
    import noc_route_pkg::*;
(
    input  route_hdr_t hdr,
    output port_id_t   hop_port,
    output route_hdr_t next_hdr
);

    // source routing: each hop eats the low port field of the header
    // and hands the rest on to the next router

    port_id_t   hop_field;
    route_hdr_t remaining;

    always_comb
    begin
        hop_field = hdr[PORT_W-1:0];
        // zeros fill from the top as the route gets shorter
        remaining = hdr >> PORT_W;
    end

    assign hop_port = hop_field;
    assign next_hdr = remaining;

endmodule

`default_nettype wire

/* hw/route_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module route_sequencer
    import noc_route_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      compute_address,
    input  logic      stall,
    output seq_ctrl_t ctrl,
    output logic      current_address_ready,
    output logic      next_address_ready,
    output logic      send_finish
);

    localparam int CNT_BITS = $clog2(FLITS_PER_HDR);
    localparam logic [CNT_BITS-1:0] LAST_FLIT = CNT_BITS'(FLITS_PER_HDR - 1);

    seq_state_t state;
    seq_state_t state_next;

    // shared by collect and send, wraps back to zero after the last flit
    logic [CNT_BITS-1:0] flit_cnt;

    logic sending;
    logic last_flit;

    assign sending = (state == SEND) || (state == HOLD);
    assign last_flit = (flit_cnt == LAST_FLIT);

    // the first flit is taken in the same cycle as compute_address
    always_comb
    begin
        ctrl.shift_in = ((state == IDLE) && compute_address) || (state == COLLECT);
        ctrl.load_route = (state == ROUTE);
        ctrl.shift_out = sending && !stall;
    end

    assign current_address_ready = (state == ROUTE);
    assign next_address_ready = sending;
    assign send_finish = ctrl.shift_out && last_flit;

    always_comb
    begin
        state_next = state;
        unique case (state)
            IDLE:
            begin
                if (compute_address)
                    state_next = COLLECT;
            end
            COLLECT:
            begin
                // stall does not apply while collecting
                if (last_flit)
                    state_next = ROUTE;
            end
            ROUTE:
            begin
                state_next = SEND;
            end
            SEND, HOLD:
            begin
                if (stall)
                    state_next = HOLD;
                else if (last_flit)
                    state_next = IDLE;
                else
                    state_next = SEND;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            flit_cnt <= '0;
        end
        else
        begin
            state <= state_next;
            if (ctrl.shift_in || ctrl.shift_out)
                flit_cnt <= flit_cnt + 1'b1;
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        $onehot0({ctrl.shift_in, ctrl.load_route, ctrl.shift_out}));

    a_finish_in_send: assert property (@(posedge clk) disable iff (reset)
        send_finish |-> next_address_ready);

endmodule

`default_nettype wire

/* hw/route_datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module route_datapath
    import noc_route_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  seq_ctrl_t    ctrl,
    input  route_cfg_t   cfg,
    input  flit_t        address_flit_in,
    input  port_id_t     hop_port,
    input  route_hdr_t   next_hdr,
    output route_hdr_t   cur_hdr,
    output port_id_t     destination_port,
    output flit_t        next_address_flit,
    output route_event_t route_event
);

    route_hdr_t in_hdr;
    route_hdr_t out_hdr;
    logic       redirect;
    port_id_t   port_sel;

    // a disabled port falls back to the configured port
    assign redirect = !cfg.port_enable[hop_port];
    assign port_sel = redirect ? cfg.fallback_port : hop_port;

    // new flit enters at the top, first flit ends up lowest
    always_ff @(posedge clk)
    begin
        if (ctrl.shift_in)
            in_hdr <= {address_flit_in, in_hdr[HDR_W-1:FLIT_W]};
    end

    assign cur_hdr = in_hdr;

    // outgoing header, lowest flit always on the link
    always_ff @(posedge clk)
    begin
        if (ctrl.load_route)
            out_hdr <= next_hdr;
        else if (ctrl.shift_out)
            out_hdr <= {{FLIT_W{1'b0}}, out_hdr[HDR_W-1:FLIT_W]};
    end

    assign next_address_flit = out_hdr[FLIT_W-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            destination_port <= '0;
            route_event <= '0;
        end
        else
        begin
            if (ctrl.load_route)
                destination_port <= port_sel;
            route_event.routed <= ctrl.load_route;
            route_event.redirected <= ctrl.load_route && redirect;
        end
    end

    // loaded port checked against the mask that was in force at the load
    a_port_legal: assert property (@(posedge clk) disable iff (reset)
        ctrl.load_route |=>
            (|($past(cfg.port_enable) & (port_mask_t'(1) << destination_port)))
            || (destination_port == $past(cfg.fallback_port)));

endmodule

`default_nettype wire

/* hw/route_config_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module route_config_regs
    import noc_route_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    output route_cfg_t        cfg,
    input  route_event_t      route_event
);

    localparam logic [APB_AW-1:0] ADDR_PORT_ENABLE = APB_AW'(4'h0);
    localparam logic [APB_AW-1:0] ADDR_FALLBACK = APB_AW'(4'h4);
    localparam logic [APB_AW-1:0] ADDR_ROUTED = APB_AW'(4'h8);
    localparam logic [APB_AW-1:0] ADDR_REDIRECT = APB_AW'(4'hc);

    count_t routed_count;
    count_t redirect_count;
    logic   access;
    logic   mapped;
    logic   read_only;
    logic   write_en;

    assign access = psel && penable;
    assign mapped = (paddr == ADDR_PORT_ENABLE) || (paddr == ADDR_FALLBACK)
        || (paddr == ADDR_ROUTED) || (paddr == ADDR_REDIRECT);
    assign read_only = (paddr == ADDR_ROUTED) || (paddr == ADDR_REDIRECT);

    // no wait states
    assign pready = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && read_only));
    assign write_en = access && pwrite && !pslverr;

    always_comb
    begin
        case (paddr)
            ADDR_PORT_ENABLE: prdata = APB_DW'(cfg.port_enable);
            ADDR_FALLBACK:    prdata = APB_DW'(cfg.fallback_port);
            ADDR_ROUTED:      prdata = APB_DW'(routed_count);
            ADDR_REDIRECT:    prdata = APB_DW'(redirect_count);
            default:          prdata = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // all ports open after reset
            cfg.port_enable <= '1;
            cfg.fallback_port <= '0;
            routed_count <= '0;
            redirect_count <= '0;
        end
        else
        begin
            if (write_en && (paddr == ADDR_PORT_ENABLE))
                cfg.port_enable <= pwdata[NUM_PORTS-1:0];
            if (write_en && (paddr == ADDR_FALLBACK))
                cfg.fallback_port <= pwdata[PORT_W-1:0];
            // counters wrap
            if (route_event.routed)
                routed_count <= routed_count + 1'b1;
            if (route_event.redirected)
                redirect_count <= redirect_count + 1'b1;
        end
    end

    a_penable_with_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

endmodule

`default_nettype wire

/* hw/noc_route_top.sv */
`timescale 1ns/1ns
`default_nettype none

module noc_route_top
    import noc_route_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              compute_address,
    input  flit_t             address_flit_in,
    input  logic              stall,
    output port_id_t          destination_port,
    output flit_t             next_address_flit,
    output logic              current_address_ready,
    output logic              next_address_ready,
    output logic              send_finish,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    seq_ctrl_t    ctrl;
    route_cfg_t   cfg;
    route_event_t route_event;
    route_hdr_t   cur_hdr;
    route_hdr_t   next_hdr;
    port_id_t     hop_port;

    route_sequencer route_sequencer_i (
        .clk                   (clk),
        .reset                 (reset),
        .compute_address       (compute_address),
        .stall                 (stall),
        .ctrl                  (ctrl),
        .current_address_ready (current_address_ready),
        .next_address_ready    (next_address_ready),
        .send_finish           (send_finish)
    );

    route_datapath route_datapath_i (
        .clk               (clk),
        .reset             (reset),
        .ctrl              (ctrl),
        .cfg               (cfg),
        .address_flit_in   (address_flit_in),
        .hop_port          (hop_port),
        .next_hdr          (next_hdr),
        .cur_hdr           (cur_hdr),
        .destination_port  (destination_port),
        .next_address_flit (next_address_flit),
        .route_event       (route_event)
    );

    route_compute route_compute_i (
        .hdr      (cur_hdr),
        .hop_port (hop_port),
        .next_hdr (next_hdr)
    );

    route_config_regs route_config_regs_i (
        .clk         (clk),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .cfg         (cfg),
        .route_event (route_event)
    );

endmodule

`default_nettype wire

/* tb/noc_route_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "noc_route_params.svh"

module noc_route_tb
    import noc_route_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [`NR_APB_AW-1:0] ADDR_PORT_ENABLE = 'h0;
    localparam logic [`NR_APB_AW-1:0] ADDR_FALLBACK = 'h4;
    localparam logic [`NR_APB_AW-1:0] ADDR_ROUTED = 'h8;
    localparam logic [`NR_APB_AW-1:0] ADDR_REDIRECT = 'hc;

    logic                  clk;
    logic                  reset;
    logic                  compute_address;
    flit_t                 address_flit_in;
    logic                  stall;
    port_id_t              destination_port;
    flit_t                 next_address_flit;
    logic                  current_address_ready;
    logic                  next_address_ready;
    logic                  send_finish;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`NR_APB_AW-1:0] paddr;
    logic [`NR_APB_DW-1:0] pwdata;
    logic [`NR_APB_DW-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // reference model
    logic [31:0]           lcg_state;
    route_hdr_t            drive_hdr;
    port_mask_t            m_mask;
    port_id_t              m_fallback;
    logic [2:0]            m_cyc;
    logic [2:0]            m_left;
    route_hdr_t            m_out;
    port_id_t              exp_port;
    count_t                m_routed;
    count_t                m_redirected;
    port_id_t              model_hop;
    logic                  model_redirect;
    logic                  exp_slverr;
    logic                  rd_check;
    logic [`NR_APB_DW-1:0] exp_rdata;
    int                    cycle_count;

    noc_route_top noc_route_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_mismatch(input string sig, input logic [31:0] expv,
        input logic [31:0] actv);
        $display("FAILED time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, sig,
            expv, actv);
        abort_run();
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic route_hdr_t random_header();
        logic [31:0] r;
        r = next_random();
        return route_hdr_t'(r >> 16);
    endfunction

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // hop rule: low port bits pick the port, a disabled port goes to the fallback
    assign model_hop = drive_hdr[PORT_W-1:0];
    assign model_redirect = !m_mask[model_hop];

    always @(posedge clk)
    begin
        if (reset)
        begin
            m_cyc <= '0;
            m_left <= '0;
            m_out <= '0;
            exp_port <= '0;
            m_routed <= '0;
            m_redirected <= '0;
        end
        else if (m_left != 3'd0)
        begin
            if (!stall)
            begin
                m_out <= m_out >> FLIT_W;
                m_left <= m_left - 3'd1;
            end
        end
        else if (m_cyc == 3'd4)
        begin
            exp_port <= model_redirect ? m_fallback : model_hop;
            m_out <= drive_hdr >> PORT_W;
            m_left <= 3'(FLITS_PER_HDR);
            m_cyc <= '0;
            m_routed <= m_routed + count_t'(1);
            if (model_redirect)
                m_redirected <= m_redirected + count_t'(1);
        end
        else if ((m_cyc != 3'd0) || compute_address)
            m_cyc <= m_cyc + 3'd1;
    end

    a_addr_ready: assert property (@(posedge clk) disable iff (reset)
        current_address_ready == (m_cyc == 3'd4))
        else value_mismatch("current_address_ready", 32'($sampled(m_cyc == 3'd4)),
            32'($sampled(current_address_ready)));

    a_next_ready: assert property (@(posedge clk) disable iff (reset)
        next_address_ready == (m_left != 3'd0))
        else value_mismatch("next_address_ready", 32'($sampled(m_left != 3'd0)),
            32'($sampled(next_address_ready)));

    a_finish: assert property (@(posedge clk) disable iff (reset)
        send_finish == ((m_left == 3'd1) && !stall))
        else value_mismatch("send_finish", 32'($sampled((m_left == 3'd1) && !stall)),
            32'($sampled(send_finish)));

    a_dest_port: assert property (@(posedge clk) disable iff (reset)
        destination_port == exp_port)
        else value_mismatch("destination_port", 32'($sampled(exp_port)),
            32'($sampled(destination_port)));

    a_flit: assert property (@(posedge clk) disable iff (reset)
        next_address_ready |-> (next_address_flit == m_out[FLIT_W-1:0]))
        else value_mismatch("next_address_flit", 32'($sampled(m_out[FLIT_W-1:0])),
            32'($sampled(next_address_flit)));

    a_pready: assert property (@(posedge clk) disable iff (reset) pready)
        else value_mismatch("pready", 32'd1, 32'($sampled(pready)));

    a_slverr: assert property (@(posedge clk) disable iff (reset)
        (psel && penable) |-> (pslverr == exp_slverr))
        else value_mismatch("pslverr", 32'($sampled(exp_slverr)), 32'($sampled(pslverr)));

    a_rdata: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && rd_check) |-> (prdata == exp_rdata))
        else value_mismatch("prdata", 32'($sampled(exp_rdata)), 32'($sampled(prdata)));

    task automatic apb_access(input logic write, input logic [`NR_APB_AW-1:0] addr,
        input logic [`NR_APB_DW-1:0] data, input logic expect_err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = write ? data : '0;
        wait_cycle();
        penable = 1'b1;
        exp_slverr = expect_err;
        exp_rdata = data;
        rd_check = !write && !expect_err;
        wait_cycle();
        psel = 1'b0;
        penable = 1'b0;
        rd_check = 1'b0;
        exp_slverr = 1'b0;
    endtask

    task automatic apb_write(input logic [`NR_APB_AW-1:0] addr,
        input logic [`NR_APB_DW-1:0] data, input logic expect_err);
        apb_access(1'b1, addr, data, expect_err);
        if (!expect_err && (addr == ADDR_PORT_ENABLE))
            m_mask = data[NUM_PORTS-1:0];
        if (!expect_err && (addr == ADDR_FALLBACK))
            m_fallback = data[PORT_W-1:0];
    endtask

    // sends one header and waits for send_finish, stall is random when enabled
    task automatic route_header(input route_hdr_t hdr, input logic use_stall);
        logic [31:0] r;
        logic done;
        drive_hdr = hdr;
        compute_address = 1'b1;
        for (int i = 0; i < FLITS_PER_HDR; i++)
        begin
            address_flit_in = hdr[i*FLIT_W +: FLIT_W];
            r = next_random();
            stall = use_stall && (r[7:4] < 4'd7);
            wait_cycle();
            compute_address = 1'b0;
        end
        done = 1'b0;
        while (!done)
        begin
            r = next_random();
            stall = use_stall && (r[7:4] < 4'd7);
            #1;
            done = send_finish;
            wait_cycle();
        end
        stall = 1'b0;
    endtask

    initial
    begin
        logic [31:0] r;
        route_hdr_t h;
        port_mask_t mask;
        reset = 1'b1;
        compute_address = 1'b0;
        address_flit_in = '0;
        stall = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lcg_state = 32'h2039_415b;
        drive_hdr = '0;
        m_mask = '1;
        m_fallback = '0;
        exp_slverr = 1'b0;
        rd_check = 1'b0;
        exp_rdata = '0;
        repeat (5) wait_cycle();
        reset = 1'b0;

        apb_access(1'b0, ADDR_PORT_ENABLE, 32'h0000_00ff, 1'b0);
        apb_access(1'b0, ADDR_FALLBACK, 32'h0, 1'b0);

        // all ports open, no back-pressure
        for (int n = 0; n < 40; n++)
            route_header(random_header(), 1'b0);

        for (int n = 0; n < 30; n++)
            route_header(random_header(), 1'b1);

        // the top port is always disabled and port 0 always enabled
        repeat (3)
        begin
            r = next_random();
            mask = port_mask_t'(r >> 16);
            mask[NUM_PORTS-1] = 1'b0;
            mask[0] = 1'b1;
            apb_write(ADDR_PORT_ENABLE, 32'(mask), 1'b0);
            apb_write(ADDR_FALLBACK, 32'(port_id_t'(r >> 8)), 1'b0);
            apb_access(1'b0, ADDR_PORT_ENABLE, 32'(m_mask), 1'b0);
            apb_access(1'b0, ADDR_FALLBACK, 32'(m_fallback), 1'b0);
            h = random_header();
            route_header({h[HDR_W-1:PORT_W], port_id_t'(NUM_PORTS - 1)}, 1'b0);
            route_header({h[HDR_W-1:PORT_W], port_id_t'(0)}, 1'b1);
            for (int n = 0; n < 8; n++)
                route_header(random_header(), n[0]);
        end

        apb_access(1'b0, ADDR_ROUTED, 32'(m_routed), 1'b0);
        apb_access(1'b0, ADDR_REDIRECT, 32'(m_redirected), 1'b0);
        // error responses must leave every register as it was
        apb_write(ADDR_ROUTED, 32'h0000_1234, 1'b1);
        apb_write(ADDR_REDIRECT, 32'h0000_0042, 1'b1);
        apb_write(`NR_APB_AW'('h6), 32'h0000_00ff, 1'b1);
        apb_access(1'b0, `NR_APB_AW'('h2), 32'h0, 1'b1);
        apb_access(1'b0, ADDR_ROUTED, 32'(m_routed), 1'b0);
        apb_access(1'b0, ADDR_REDIRECT, 32'(m_redirected), 1'b0);
        apb_access(1'b0, ADDR_PORT_ENABLE, 32'(m_mask), 1'b0);
        apb_access(1'b0, ADDR_FALLBACK, 32'(m_fallback), 1'b0);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* noc_route.f */
+incdir+include
hw/noc_route_pkg.sv
hw/route_compute.sv
hw/route_sequencer.sv
hw/route_datapath.sv
hw/route_config_regs.sv
hw/noc_route_top.sv
tb/noc_route_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the noc_route testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module noc_route_tb \
    -f noc_route.f -Mdir obj_dir -o noc_route_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/noc_route_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
